/* Makefile */
SRCS = $(wildcard hw/*.sv) $(wildcard include/*.svh) $(wildcard test/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_rip_core
	./obj_dir/Vtb_rip_core > sim.log 2>&1 || true
	cat sim.log
	grep -q "all tests passed" sim.log

obj_dir/Vtb_rip_core: tb.f $(SRCS)
	verilator --binary --timing --assert -Iinclude -f tb.f \
		--top-module tb_rip_core -o Vtb_rip_core

clean:
	rm -rf obj_dir sim.log

/* hw/rip_alu.sv */
module rip_alu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  de_valid,
    input  rip_isa_pkg::alu_op_e  de_op,
    input  logic                  de_use_imm,
    input  rip_isa_pkg::reg_idx_t de_rd,
    input  rip_isa_pkg::word_t    de_a,
    input  rip_isa_pkg::word_t    de_b,
    input  rip_isa_pkg::word_t    de_imm,
    input  logic                  de_illegal,
    output logic                  wen,
    output rip_isa_pkg::reg_idx_t wr_idx,
    output rip_isa_pkg::word_t    wr_data,
    output logic                  wb_valid,
    output rip_isa_pkg::reg_idx_t wb_rd,
    output rip_isa_pkg::word_t    wb_data,
    output logic                  illegal
);
    import rip_isa_pkg::*;
    import rip_pipe_pkg::*;

    word_t                 op_b;
    logic [shamt_bits-1:0] shamt;
    logic                  lt_signed;
    logic                  lt_unsigned;
    word_t                 result;

    assign op_b  = de_use_imm ? de_imm : de_b;
    assign shamt = op_b[shamt_bits-1:0];

    assign lt_signed   = $signed(de_a) < $signed(op_b);
    assign lt_unsigned = de_a < op_b;

    always_comb begin
        case (de_op)
            ALU_ADD:  result = de_a + op_b;
            ALU_SUB:  result = de_a - op_b;
            ALU_AND:  result = de_a & op_b;
            ALU_OR:   result = de_a | op_b;
            ALU_XOR:  result = de_a ^ op_b;
            ALU_SLL:  result = de_a << shamt;
            ALU_SRL:  result = de_a >> shamt;
            ALU_SRA:  result = word_t'($signed(de_a) >>> shamt);
            ALU_SLT:  result = word_t'(lt_signed);
            ALU_SLTU: result = word_t'(lt_unsigned);
            // upper immediate already placed by decode
            ALU_LUI:  result = op_b;
            default:  result = '0;
        endcase
    end

    // regfile write, same edge as the report
    assign wen     = de_valid && !de_illegal;
    assign wr_idx  = de_rd;
    assign wr_data = result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            illegal  <= 1'b0;
        end
        else begin
            wb_valid <= wen;
            illegal  <= de_valid && de_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            wb_rd   <= de_rd;
            wb_data <= result;
        end
    end

    a_report_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(wb_valid && illegal));

endmodule

/* hw/rip_core.sv */
module rip_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  rip_isa_pkg::word_t    inst_code,
    output logic                  wb_valid,
    output rip_isa_pkg::reg_idx_t wb_rd,
    output rip_isa_pkg::word_t    wb_data,
    output logic                  illegal
);
    import rip_isa_pkg::*;

    // decode to regfile
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_val;
    word_t    rs2_val;

    // decode stage register
    logic     de_valid;
    alu_op_e  de_op;
    logic     de_use_imm;
    reg_idx_t de_rd;
    word_t    de_a;
    word_t    de_b;
    word_t    de_imm;
    logic     de_illegal;

    // alu write port
    logic     wen;
    reg_idx_t wr_idx;
    word_t    wr_data;

    rip_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_code  (inst_code),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .de_valid   (de_valid),
        .de_op      (de_op),
        .de_use_imm (de_use_imm),
        .de_rd      (de_rd),
        .de_a       (de_a),
        .de_b       (de_b),
        .de_imm     (de_imm),
        .de_illegal (de_illegal)
    );

    rip_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .wen     (wen),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    rip_alu u_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .de_valid   (de_valid),
        .de_op      (de_op),
        .de_use_imm (de_use_imm),
        .de_rd      (de_rd),
        .de_a       (de_a),
        .de_b       (de_b),
        .de_imm     (de_imm),
        .de_illegal (de_illegal),
        .wen        (wen),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .illegal    (illegal)
    );

endmodule

/* hw/rip_decode.sv */
module rip_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  rip_isa_pkg::word_t    inst_code,
    input  rip_isa_pkg::word_t    rs1_val,
    input  rip_isa_pkg::word_t    rs2_val,
    output rip_isa_pkg::reg_idx_t rs1_idx,
    output rip_isa_pkg::reg_idx_t rs2_idx,
    output logic                  de_valid,
    output rip_isa_pkg::alu_op_e  de_op,
    output logic                  de_use_imm,
    output rip_isa_pkg::reg_idx_t de_rd,
    output rip_isa_pkg::word_t    de_a,
    output rip_isa_pkg::word_t    de_b,
    output rip_isa_pkg::word_t    de_imm,
    output logic                  de_illegal
);
    import rip_isa_pkg::*;
    import rip_pipe_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       is_shift;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_shamt;
    alu_op_e    f3_op;
    alu_op_e    dec_op;
    logic       dec_use_imm;
    word_t      dec_imm;
    logic       dec_illegal;

    assign opcode   = inst_code[6:0];
    assign funct3   = inst_code[funct3_lsb +: 3];
    assign funct7   = inst_code[funct7_lsb +: 7];
    assign rs1_idx  = inst_code[rs1_lsb +: reg_idx_bits];
    assign rs2_idx  = inst_code[rs2_lsb +: reg_idx_bits];
    assign alt      = (funct7 == f7_alt);
    assign is_shift = (funct3 == f3_sll) || (funct3 == f3_srl_sra);

    assign imm_i     = {{20{inst_code[31]}}, inst_code[31:20]};
    assign imm_u     = {inst_code[31:12], 12'h000};
    assign imm_shamt = word_t'(inst_code[rs2_lsb +: shamt_bits]);

    // funct3 to operation, alt picks SUB / SRA
    always_comb begin
        case (funct3)
            f3_add_sub: f3_op = alt ? ALU_SUB : ALU_ADD;
            f3_sll:     f3_op = ALU_SLL;
            f3_slt:     f3_op = ALU_SLT;
            f3_sltu:    f3_op = ALU_SLTU;
            f3_xor:     f3_op = ALU_XOR;
            f3_srl_sra: f3_op = alt ? ALU_SRA : ALU_SRL;
            f3_or:      f3_op = ALU_OR;
            default:    f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        dec_op      = ALU_ADD;
        dec_use_imm = 1'b0;
        dec_imm     = imm_i;
        dec_illegal = 1'b0;
        case (opcode)
            opc_op: begin
                dec_op      = f3_op;
                dec_illegal = !((funct7 == f7_base) ||
                                (alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra)));
            end
            opc_op_imm: begin
                dec_use_imm = 1'b1;
                if (is_shift) begin
                    dec_op      = f3_op;
                    dec_imm     = imm_shamt;
                    dec_illegal = !((funct7 == f7_base) || (alt && funct3 == f3_srl_sra));
                end
                else begin
                    // imm bit 30 must not turn ADDI into SUB
                    dec_op = (funct3 == f3_add_sub) ? ALU_ADD : f3_op;
                end
            end
            opc_lui: begin
                dec_op      = ALU_LUI;
                dec_use_imm = 1'b1;
                dec_imm     = imm_u;
            end
            default: dec_illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_valid   <= 1'b0;
            de_illegal <= 1'b0;
        end
        else begin
            de_valid   <= inst_valid;
            de_illegal <= inst_valid && dec_illegal;
        end
    end

    // payload, qualified by de_valid
    always_ff @(posedge clk) begin
        de_op      <= dec_op;
        de_use_imm <= dec_use_imm;
        de_rd      <= inst_code[rd_lsb +: reg_idx_bits];
        de_a       <= rs1_val;
        de_b       <= rs2_val;
        de_imm     <= dec_imm;
    end

    a_illegal_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) de_illegal |-> de_valid);

endmodule

/* hw/rip_isa_pkg.sv */
package rip_isa_pkg;

    localparam int xlen = 32;
    localparam int reg_idx_bits = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_idx_bits-1:0] reg_idx_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    // funct3, shared by register and immediate forms
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7, alt marks SUB and SRA/SRAI
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // field positions in the instruction word
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

    // immediate forms reuse these codes
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

endpackage

/* hw/rip_pipe_pkg.sv */
package rip_pipe_pkg;

    // architectural register count, x0 included
    localparam int num_regs = 32;

    // low operand bits used by the shifter
    localparam int shamt_bits = 5;

    // cycles from accept edge to the writeback report
    localparam int pipe_latency = 2;

    // instructions in flight at most, one per stage
    localparam int max_in_flight = pipe_latency;

endpackage

/* hw/rip_regfile.sv */
module rip_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rip_isa_pkg::reg_idx_t rs1_idx,
    input  rip_isa_pkg::reg_idx_t rs2_idx,
    input  logic                  wen,
    input  rip_isa_pkg::reg_idx_t wr_idx,
    input  rip_isa_pkg::word_t    wr_data,
    output rip_isa_pkg::word_t    rs1_val,
    output rip_isa_pkg::word_t    rs2_val
);
    import rip_isa_pkg::*;
    import rip_pipe_pkg::*;

    // x0 has no storage
    word_t regs [1:num_regs-1];
    logic  rs1_hit;
    logic  rs2_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end
        else if (wen && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // bypass the write landing at the next edge
    assign rs1_hit = wen && (rs1_idx == wr_idx);
    assign rs2_hit = wen && (rs2_idx == wr_idx);

    assign rs1_val = (rs1_idx == '0) ? '0 :
                     rs1_hit         ? wr_data :
                                       regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 :
                     rs2_hit         ? wr_data :
                                       regs[rs2_idx];

    a_rs1_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n) (rs1_idx == '0) |-> (rs1_val == '0));
    a_rs2_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n) (rs2_idx == '0) |-> (rs2_val == '0));

endmodule

/* tb.f */
+incdir+include
hw/rip_isa_pkg.sv
hw/rip_pipe_pkg.sv
hw/rip_decode.sv
hw/rip_regfile.sv
hw/rip_alu.sv
hw/rip_core.sv
test/tb_rip_core.sv

/* include/rip_tb_model.svh */
`ifndef RIP_TB_MODEL_SVH
`define RIP_TB_MODEL_SVH

// instruction encoders
function automatic word_t enc_r(logic [6:0] funct7, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] funct3, reg_idx_t rd);
    return {funct7, rs2, rs1, funct3, rd, opc_op};
endfunction

function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] funct3,
                                reg_idx_t rd);
    return {imm, rs1, funct3, rd, opc_op_imm};
endfunction

function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd);
    return {imm, rd, opc_lui};
endfunction

// true for the encodings the core executes
function automatic logic model_legal(word_t inst);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    opcode = inst[6:0];
    f3     = inst[14:12];
    f7     = inst[31:25];
    if (opcode == opc_lui) return 1'b1;
    if (opcode == opc_op) begin
        return (f7 == f7_base) || (f7 == f7_alt && (f3 == f3_add_sub || f3 == f3_srl_sra));
    end
    if (opcode != opc_op_imm) return 1'b0;
    if (f3 == f3_sll) return f7 == f7_base;
    if (f3 == f3_srl_sra) return (f7 == f7_base) || (f7 == f7_alt);
    return 1'b1;
endfunction

// expected result from the operand register values a and b
function automatic word_t model_result(word_t inst, word_t a, word_t b);
    logic [6:0] opcode;
    word_t      y;
    logic [4:0] sh;
    logic       alt;
    opcode = inst[6:0];
    if (opcode == opc_lui) return {inst[31:12], 12'h000};
    y   = (opcode == opc_op) ? b : {{20{inst[31]}}, inst[31:20]};
    sh  = y[4:0];
    alt = inst[30];
    case (inst[14:12])
        f3_add_sub: return (opcode == opc_op && alt) ? a - y : a + y;
        f3_sll:     return a << sh;
        f3_slt:     return ($signed(a) < $signed(y)) ? 32'd1 : 32'd0;
        f3_sltu:    return (a < y) ? 32'd1 : 32'd0;
        f3_xor:     return a ^ y;
        f3_srl_sra: return alt ? word_t'($signed(a) >>> sh) : a >> sh;
        f3_or:      return a | y;
        default:    return a & y;
    endcase
endfunction

`endif

/* test/tb_rip_core.sv */
module tb_rip_core;
    timeunit 1ns;
    timeprecision 1ps;

    import rip_isa_pkg::*;
    import rip_pipe_pkg::*;

    `include "rip_tb_model.svh"

    localparam int num_cycles  = 3000;
    localparam int idle_cycles = 10;

    typedef struct packed {
        logic     wb;
        logic     ill;
        reg_idx_t rd;
        word_t    data;
    } exp_t;

    logic     clk;
    logic     rst_n;
    logic     inst_valid;
    word_t    inst_code;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     illegal;

    word_t model_regs [0:num_regs-1];
    exp_t  exp_q [$];
    int    seed;
    int    errors;
    int    checks;

    rip_core u_rip_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_code  (inst_code),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // mostly x0..x7 so dependences and x0 come up often
    task automatic pick_reg(output reg_idx_t idx);
        logic [31:0] r;
        r   = $random(seed);
        idx = (r[4:3] != 2'b00) ? reg_idx_t'(r[2:0]) : r[9:5];
    endtask

    task automatic gen_inst(output word_t inst);
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] kind;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        r    = $random(seed);
        r2   = $random(seed);
        kind = r % 100;
        f3   = r[18:16];
        f7   = (r[20] && (f3 == f3_add_sub || f3 == f3_srl_sra)) ? f7_alt : f7_base;
        pick_reg(rd);
        pick_reg(rs1);
        pick_reg(rs2);
        if (kind < 5) begin
            // bad funct7 on OP, or the SYSTEM opcode
            inst = r[21] ? enc_r(7'b0000001, rs2, rs1, f3, rd) : {r2[31:7], 7'b1110011};
        end
        else if (kind < 45) begin
            inst = enc_r(f7, rs2, rs1, f3, rd);
        end
        else if (kind < 85) begin
            imm = r2[11:0];
            if (f3 == f3_sll || f3 == f3_srl_sra) begin
                imm = {f7, r2[4:0]};
            end
            inst = enc_i(imm, rs1, f3, rd);
        end
        else begin
            inst = enc_u(r2[19:0], rd);
        end
    endtask

    // drives one cycle and queues what it should produce
    task automatic issue_inst(input logic valid, input word_t inst);
        exp_t  e;
        word_t a;
        word_t b;
        e.wb   = 1'b0;
        e.ill  = 1'b0;
        e.rd   = inst[11:7];
        e.data = '0;
        if (valid) begin
            if (model_legal(inst)) begin
                a      = model_regs[inst[19:15]];
                b      = model_regs[inst[24:20]];
                e.wb   = 1'b1;
                e.data = model_result(inst, a, b);
                if (e.rd != '0) begin
                    model_regs[e.rd] = e.data;
                end
            end
            else begin
                e.ill = 1'b1;
            end
        end
        exp_q.push_back(e);
        inst_valid = valid;
        inst_code  = inst;
    endtask

    task automatic check_wb(input reg_idx_t exp_rd, input word_t exp_data);
        checks++;
        if (wb_rd !== exp_rd) begin
            errors++;
            $display("FAIL wb_rd expected %h actual %h at %0t", exp_rd, wb_rd, $time);
        end
        if (wb_data !== exp_data) begin
            errors++;
            $display("FAIL wb_data expected %h actual %h at %0t", exp_data, wb_data, $time);
        end
    endtask

    task automatic check_illegal(input logic exp_ill);
        checks++;
        if (illegal !== exp_ill) begin
            errors++;
            if (exp_ill) begin
                $display("illegal did not pulse for an illegal instruction at %0t", $time);
            end
            else begin
                $display("illegal pulsed with no illegal instruction at %0t", $time);
            end
        end
    endtask

    task automatic check_report(input exp_t e);
        if (e.wb && wb_valid !== 1'b1) begin
            errors++;
            $display("wb_valid missing for a legal instruction at %0t", $time);
        end
        else if (!e.wb && wb_valid !== 1'b0) begin
            errors++;
            $display("wb_valid raised with no instruction to report at %0t", $time);
        end
        else if (e.wb) begin
            check_wb(e.rd, e.data);
        end
        check_illegal(e.ill);
    endtask

    initial begin
        word_t inst;
        seed       = 32'hfc73;
        errors     = 0;
        checks     = 0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst_code  = '0;
        for (int i = 0; i < num_regs; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int cyc = 0; cyc < num_cycles + pipe_latency; cyc++) begin
            if (exp_q.size() == pipe_latency) begin
                check_report(exp_q.pop_front());
            end
            gen_inst(inst);
            if (cyc >= idle_cycles && cyc < num_cycles &&
                ($unsigned($random(seed)) % 10) < 8) begin
                issue_inst(1'b1, inst);
            end
            else begin
                issue_inst(1'b0, inst);
            end
            @(negedge clk);
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("all tests passed");
        end
        else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #((num_cycles + 50) * 8);
        $display("run did not finish in time, %0d errors so far", errors);
        $display("tests failed");
        $finish;
    end

endmodule
